// File: Makefile
# Verilator build and run of the IPv4 checksum testbench

VERILATOR ?= verilator
TOP       ?= ipv4_checksum_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/ipv4_checksum_pkg.sv
// Types for 20-byte IPv4 headers in wire order
// Streams have no ready signal so every beat must be accepted

`default_nettype none

package ipv4_checksum_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Header layout

    // Version sits in the most significant bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  hdr_len;
        logic [7:0]  tos;
        logic [15:0] length;
        logic [15:0] id;
        logic [2:0]  flags;
        logic [12:0] offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_chk;
        logic [31:0] src;
        logic [31:0] dst;
    } ipv4_header_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stream items

    // One header transfer
    typedef struct packed {
        logic         valid;
        ipv4_header_t hdr;
    } ipv4_hdr_beat_t;

    // One receive path verdict
    typedef struct packed {
        logic valid;
        logic checksum_ok;
        logic format_ok;
    } ipv4_check_t;

endpackage

`default_nettype wire

// File: common/ipv4_checksum_settings.svh
// Fixed IPv4 header format of 20 bytes with no options
// The sum pipeline depth may be 1, 2 or 3 register stages

`ifndef IPV4_CHECKSUM_SETTINGS_SVH
`define IPV4_CHECKSUM_SETTINGS_SVH

// Expected version field
`define IPV4_VERSION 4

// Expected header length in 32-bit words
`define IPV4_IHL 5

// 16-bit words covered by the checksum
`define IPV4_HDR_WORDS 10

// Register stages inside the ones'-complement adder
`define IPV4_SUM_STAGES 2

`endif

// File: design/ipv4_checksum_gen.sv
// Incoming hdr_chk is ignored and replaced by the computed checksum
// Latency is IPV4_SUM_STAGES + 1 cycles with one header accepted per clock

`default_nettype none

`include "ipv4_checksum_settings.svh"

module ipv4_checksum_gen
    import ipv4_checksum_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire ipv4_hdr_beat_t  hdr_in,
    output ipv4_hdr_beat_t       hdr_out
);

    localparam int STAGES = `IPV4_SUM_STAGES;

    logic           sum_valid;
    logic [15:0]    sum;
    ipv4_header_t   hdr_dly [STAGES];
    logic           out_valid;
    ipv4_header_t   out_hdr;

    ////////////////////////////////////////////////////////////////////////////
    // Sum over the header with the checksum field masked

    ipv4_header_sum sum0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (hdr_in.valid),
        .header    (hdr_in.hdr),
        .mask_chk  (1'b1),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Header delay line

    // Same depth as the sum pipeline so each header meets its own sum
    always_ff @(posedge clk) begin
        hdr_dly[0] <= hdr_in.hdr;
        for (int i = 1; i < STAGES; i++) begin
            hdr_dly[i] <= hdr_dly[i-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sum_valid;
        end
    end

    // Checksum is the complement of the ones'-complement sum
    always_ff @(posedge clk) begin
        out_hdr         <= hdr_dly[STAGES-1];
        out_hdr.hdr_chk <= ~sum;
    end

    assign hdr_out.valid = out_valid;
    assign hdr_out.hdr   = out_hdr;

endmodule

`default_nettype wire

// File: design/ipv4_checksum_top.sv
// Transmit and receive paths run independently with equal fixed latency
// No back-pressure so both input streams may carry a header every clock

`default_nettype none

module ipv4_checksum_top
    import ipv4_checksum_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,

    // Transmit path
    input  wire ipv4_hdr_beat_t  tx_in,
    output ipv4_hdr_beat_t       tx_out,

    // Receive path
    input  wire ipv4_hdr_beat_t  rx_in,
    output ipv4_check_t          rx_result
);

    ////////////////////////////////////////////////////////////////////////////
    // Checksum insertion

    ipv4_checksum_gen gen0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .hdr_in  (tx_in),
        .hdr_out (tx_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checksum and format check

    ipv4_checksum_verify verify0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .hdr_in  (rx_in),
        .result  (rx_result)
    );

endmodule

`default_nettype wire

// File: design/ipv4_checksum_verify.sv
// Only version 4 with IHL 5 counts as a valid format and options are not summed
// Latency is IPV4_SUM_STAGES + 1 cycles with one header accepted per clock

`default_nettype none

`include "ipv4_checksum_settings.svh"

module ipv4_checksum_verify
    import ipv4_checksum_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire ipv4_hdr_beat_t  hdr_in,
    output ipv4_check_t          result
);

    localparam int STAGES = `IPV4_SUM_STAGES;

    logic               sum_valid;
    logic [15:0]        sum;
    logic               fmt_in;
    logic [STAGES-1:0]  fmt_dly;
    logic               res_valid;
    logic               res_chk_ok;
    logic               res_fmt_ok;

    ////////////////////////////////////////////////////////////////////////////
    // Sum over all ten words including the received checksum

    ipv4_header_sum sum0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (hdr_in.valid),
        .header    (hdr_in.hdr),
        .mask_chk  (1'b0),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Format check

    assign fmt_in = (hdr_in.hdr.version == 4'(`IPV4_VERSION)) &&
                    (hdr_in.hdr.hdr_len == 4'(`IPV4_IHL));

    // Delayed to line up with the sum
    always_ff @(posedge clk) begin
        fmt_dly[0] <= fmt_in;
        for (int i = 1; i < STAGES; i++) begin
            fmt_dly[i] <= fmt_dly[i-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= sum_valid;
        end
    end

    // A correct header sums to all ones
    always_ff @(posedge clk) begin
        res_chk_ok <= (sum == 16'hFFFF);
        res_fmt_ok <= fmt_dly[STAGES-1];
    end

    assign result.valid       = res_valid;
    assign result.checksum_ok = res_chk_ok;
    assign result.format_ok   = res_fmt_ok;

endmodule

`default_nettype wire

// File: design/ipv4_header_sum.sv
// Result is valid IPV4_SUM_STAGES cycles after in_valid and the pipeline never stalls
// Depths of 1 to 3 are supported

`default_nettype none

`include "ipv4_checksum_settings.svh"

module ipv4_header_sum
    import ipv4_checksum_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire logic         in_valid,
    input  wire ipv4_header_t header,
    input  wire logic         mask_chk,
    output logic              sum_valid,
    output logic [15:0]       sum
);

    localparam int STAGES = `IPV4_SUM_STAGES;
    localparam int HALF   = `IPV4_HDR_WORDS / 2;

    ipv4_header_t                           hdr_m;
    logic [`IPV4_HDR_WORDS-1:0][15:0]       words;
    logic [19:0]                            part_a;
    logic [19:0]                            part_b;
    logic [19:0]                            part_a_s;
    logic [19:0]                            part_b_s;
    logic [20:0]                            total;
    logic [20:0]                            total_s;
    logic [16:0]                            fold1;
    logic [15:0]                            fold2;
    logic [STAGES-1:0]                      valid_sr;

    ////////////////////////////////////////////////////////////////////////////
    // Word split and partial sums

    // Transmit path zeroes the checksum word before summing
    always_comb begin
        hdr_m = header;
        if (mask_chk) begin
            hdr_m.hdr_chk = '0;
        end
    end

    assign words = hdr_m;

    // Five 16-bit words cannot overflow 20 bits
    always_comb begin
        part_a = '0;
        part_b = '0;
        for (int i = 0; i < HALF; i++) begin
            part_a = part_a + 20'(words[i + HALF]);
            part_b = part_b + 20'(words[i]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Adder tree split by pipeline depth

    generate
        if (STAGES >= 2) begin : g_part_reg
            always_ff @(posedge clk) begin
                part_a_s <= part_a;
                part_b_s <= part_b;
            end
        end else begin : g_part_comb
            assign part_a_s = part_a;
            assign part_b_s = part_b;
        end
    endgenerate

    assign total = 21'(part_a_s) + 21'(part_b_s);

    generate
        if (STAGES >= 3) begin : g_total_reg
            always_ff @(posedge clk) begin
                total_s <= total;
            end
        end else begin : g_total_comb
            assign total_s = total;
        end
    endgenerate

    // End-around carry folded twice
    assign fold1 = 17'(total_s[15:0]) + 17'(total_s[20:16]);
    assign fold2 = fold1[15:0] + 16'(fold1[16]);

    always_ff @(posedge clk) begin
        sum <= fold2;
    end

    // Valid follows the data through the same number of stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= in_valid;
            for (int i = 1; i < STAGES; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    assign sum_valid = valid_sr[STAGES-1];

endmodule

`default_nettype wire

// File: flist.f
+incdir+common
common/ipv4_checksum_pkg.sv
design/ipv4_header_sum.sv
design/ipv4_checksum_gen.sv
design/ipv4_checksum_verify.sv
design/ipv4_checksum_top.sv
sim/tb_clock_gen.sv
sim/ipv4_checksum_tb.sv

// File: sim/ipv4_checksum_tb.sv
// Inputs change on the falling edge and outputs are checked there too
// Expected latency comes from IPV4_SUM_STAGES in the settings header

`default_nettype none

`include "ipv4_checksum_settings.svh"

module ipv4_checksum_tb
    import ipv4_checksum_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LATENCY     = `IPV4_SUM_STAGES + 1;
    localparam int DRAIN_LIMIT = 50;

    typedef struct packed {
        ipv4_header_t hdr;
        logic [31:0]  due;
    } tx_expect_t;

    typedef struct packed {
        ipv4_check_t res;
        logic [31:0] due;
    } rx_expect_t;

    logic           clk;
    logic           rst_n;
    ipv4_hdr_beat_t tx_in;
    ipv4_hdr_beat_t tx_out;
    ipv4_hdr_beat_t rx_in;
    ipv4_check_t    rx_result;
    logic [31:0]    cyc;
    logic [31:0]    lcg_state = 32'd84727;
    tx_expect_t     tx_exp [$];
    rx_expect_t     rx_exp [$];

    tb_clock_gen #(.PERIOD_NS(4)) clk_gen0 (.clk(clk));

    ipv4_checksum_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_in     (tx_in),
        .tx_out    (tx_out),
        .rx_in     (rx_in),
        .rx_result (rx_result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and reference model

    function automatic logic [15:0] next_rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [31:0] next_rand32();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = next_rand16();
        lo = next_rand16();
        return {hi, lo};
    endfunction

    // Folded ones'-complement sum of the ten header words
    function automatic logic [15:0] ones_sum(ipv4_header_t h, logic skip_chk);
        logic [15:0] w [`IPV4_HDR_WORDS];
        logic [31:0] acc;
        w[0] = {h.version, h.hdr_len, h.tos};
        w[1] = h.length;
        w[2] = h.id;
        w[3] = {h.flags, h.offset};
        w[4] = {h.ttl, h.protocol};
        w[5] = skip_chk ? 16'h0000 : h.hdr_chk;
        w[6] = h.src[31:16];
        w[7] = h.src[15:0];
        w[8] = h.dst[31:16];
        w[9] = h.dst[15:0];
        acc = 32'd0;
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            acc = acc + {16'h0000, w[i]};
        end
        while (acc[31:16] != 16'h0000) begin
            acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
        end
        return acc[15:0];
    endfunction

    function automatic logic [15:0] model_checksum(ipv4_header_t h);
        return ~ones_sum(h, 1'b1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Header generators

    function automatic ipv4_header_t random_header();
        logic [31:0] r [5];
        for (int i = 0; i < 5; i++) begin
            r[i] = next_rand32();
        end
        return {r[0], r[1], r[2], r[3], r[4]};
    endfunction

    function automatic ipv4_header_t good_header();
        ipv4_header_t h;
        h         = random_header();
        h.version = 4'(`IPV4_VERSION);
        h.hdr_len = 4'(`IPV4_IHL);
        h.hdr_chk = model_checksum(h);
        return h;
    endfunction

    function automatic ipv4_header_t corrupt_header();
        ipv4_header_t h;
        logic [15:0]  delta;
        h     = good_header();
        delta = next_rand16();
        if (delta == 16'h0000) begin
            delta = 16'h0001;
        end
        h.hdr_chk = h.hdr_chk ^ delta;
        return h;
    endfunction

    // Version, IHL or both are wrong and the checksum may still be right
    function automatic ipv4_header_t bad_format_header();
        ipv4_header_t h;
        logic [15:0]  r;
        h = random_header();
        r = next_rand16();
        if (r[1:0] != 2'd1 && h.version == 4'(`IPV4_VERSION)) begin
            h.version = 4'd6;
        end
        if (r[1:0] != 2'd0 && h.hdr_len == 4'(`IPV4_IHL)) begin
            h.hdr_len = 4'd7;
        end
        if (r[2]) begin
            h.hdr_chk = model_checksum(h);
        end
        return h;
    endfunction

    function automatic ipv4_header_t mixed_rx_header();
        logic [15:0] r;
        r = next_rand16();
        case (r[1:0])
            2'd2:    return corrupt_header();
            2'd3:    return bad_format_header();
            default: return good_header();
        endcase
    endfunction

    function automatic ipv4_hdr_beat_t make_beat(ipv4_header_t h);
        return {1'b1, h};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks

    task automatic end_in_failure();
        $display("Test failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic value_error(string what, logic [31:0] got, logic [31:0] exp);
        $display("** Error at %0.1f ns: %s got 0x%0h expected 0x%0h",
                 $realtime, what, got, exp);
        end_in_failure();
    endtask

    task automatic plain_error(string what);
        $display("%s", what);
        end_in_failure();
    endtask

    task automatic compare_field(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            value_error({"tx header ", name}, got, exp);
        end
    endtask

    task automatic check_header(ipv4_header_t got, ipv4_header_t exp);
        compare_field("version", 32'(got.version), 32'(exp.version));
        compare_field("hdr_len", 32'(got.hdr_len), 32'(exp.hdr_len));
        compare_field("tos", 32'(got.tos), 32'(exp.tos));
        compare_field("length", 32'(got.length), 32'(exp.length));
        compare_field("id", 32'(got.id), 32'(exp.id));
        compare_field("flags", 32'(got.flags), 32'(exp.flags));
        compare_field("offset", 32'(got.offset), 32'(exp.offset));
        compare_field("ttl", 32'(got.ttl), 32'(exp.ttl));
        compare_field("protocol", 32'(got.protocol), 32'(exp.protocol));
        compare_field("hdr_chk", 32'(got.hdr_chk), 32'(exp.hdr_chk));
        compare_field("src", got.src, exp.src);
        compare_field("dst", got.dst, exp.dst);
    endtask

    task automatic check_result(ipv4_check_t got, ipv4_check_t exp);
        if (got.checksum_ok !== exp.checksum_ok) begin
            value_error("rx checksum_ok", 32'(got.checksum_ok), 32'(exp.checksum_ok));
        end else if (got.format_ok !== exp.format_ok) begin
            value_error("rx format_ok", 32'(got.format_ok), 32'(exp.format_ok));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle output check and input drive

    task automatic check_outputs();
        tx_expect_t te;
        rx_expect_t re;
        if (tx_out.valid === 1'b1) begin
            if (tx_exp.size() == 0) begin
                plain_error("Transmit output was valid while no header was expected");
            end else begin
                te = tx_exp.pop_front();
                if (te.due != cyc) begin
                    value_error("tx output cycle", cyc, te.due);
                end else begin
                    check_header(tx_out.hdr, te.hdr);
                end
            end
        end else if (tx_out.valid !== 1'b0) begin
            plain_error("Transmit output valid is unknown");
        end else if (tx_exp.size() != 0 && tx_exp[0].due <= cyc) begin
            value_error("tx output missing at cycle", cyc, tx_exp[0].due);
        end
        if (rx_result.valid === 1'b1) begin
            if (rx_exp.size() == 0) begin
                plain_error("Receive result was valid while no header was expected");
            end else begin
                re = rx_exp.pop_front();
                if (re.due != cyc) begin
                    value_error("rx result cycle", cyc, re.due);
                end else begin
                    check_result(rx_result, re.res);
                end
            end
        end else if (rx_result.valid !== 1'b0) begin
            plain_error("Receive result valid is unknown");
        end else if (rx_exp.size() != 0 && rx_exp[0].due <= cyc) begin
            value_error("rx result missing at cycle", cyc, rx_exp[0].due);
        end
    endtask

    // One clock: check what came out, then present the next inputs
    task automatic tick(input ipv4_hdr_beat_t tx, input ipv4_hdr_beat_t rx);
        tx_expect_t te;
        rx_expect_t re;
        @(negedge clk);
        cyc = cyc + 32'd1;
        check_outputs();
        tx_in = tx;
        rx_in = rx;
        if (tx.valid) begin
            te.hdr         = tx.hdr;
            te.hdr.hdr_chk = model_checksum(tx.hdr);
            te.due         = cyc + 32'(LATENCY);
            tx_exp.push_back(te);
        end
        if (rx.valid) begin
            re.res.valid       = 1'b1;
            re.res.checksum_ok = (ones_sum(rx.hdr, 1'b0) == 16'hFFFF);
            re.res.format_ok   = (rx.hdr.version == 4'(`IPV4_VERSION)) &&
                                 (rx.hdr.hdr_len == 4'(`IPV4_IHL));
            re.due             = cyc + 32'(LATENCY);
            rx_exp.push_back(re);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (tx_exp.size() != 0 || rx_exp.size() != 0) begin
            if (waited >= DRAIN_LIMIT) begin
                plain_error("Timed out waiting for the expected outputs to drain");
            end else begin
                tick('0, '0);
                waited++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        ipv4_hdr_beat_t tx_b;
        ipv4_hdr_beat_t rx_b;
        logic [15:0]    r;
        rst_n = 1'b0;
        tx_in = '0;
        rx_in = '0;
        cyc   = 32'd0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst_n = 1'b1;

        // Idle after reset so both valids must stay low
        for (int i = 0; i < 8; i++) begin
            tick('0, '0);
        end

        // Transmit only, one header per clock
        for (int i = 0; i < 40; i++) begin
            tick(make_beat(random_header()), '0);
        end
        drain();

        // Receive with good checksums, then good and corrupted mixed
        for (int i = 0; i < 30; i++) begin
            tick('0, make_beat(good_header()));
        end
        for (int i = 0; i < 40; i++) begin
            r = next_rand16();
            tick('0, make_beat(r[0] ? corrupt_header() : good_header()));
        end
        drain();

        // Wrong version or IHL
        for (int i = 0; i < 30; i++) begin
            tick('0, make_beat(bad_format_header()));
        end
        drain();

        // Both paths at once with full-rate bursts, random gaps and idle runs
        for (int i = 0; i < 300; i++) begin
            tx_b = '0;
            rx_b = '0;
            r    = next_rand16();
            if ((i % 50) < 12) begin
                tx_b = make_beat(random_header());
                rx_b = make_beat(mixed_rx_header());
            end else if ((i % 50) < 42) begin
                if (r[3:0] < 4'd10) begin
                    tx_b = make_beat(random_header());
                end
                if (r[7:4] < 4'd9) begin
                    rx_b = make_beat(mixed_rx_header());
                end
            end
            tick(tx_b, rx_b);
        end
        drain();

        // Nothing more may come out
        for (int i = 0; i < 6; i++) begin
            tick('0, '0);
        end

        if (tx_exp.size() == 0 && rx_exp.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Expected outputs were still outstanding at the end of the run");
            end_in_failure();
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// Free-running testbench clock that starts low
// Half period is PERIOD_NS / 2 so the period should be even

`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
